/* wb32_consts.svh */
// Wishbone bridge constants

`ifndef WB32_CONSTS_SVH
`define WB32_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Burst geometry
//////////////////////////////////////////////////////////////////////

// Words per wrapping read burst
`define WB_BURST_LEN 8

// Width of the beat field inside a burst line
// Must match the burst length above
`define WB_BEAT_BITS 3

//////////////////////////////////////////////////////////////////////
// On-chip SRAM slave
//////////////////////////////////////////////////////////////////////

// Depth in 32-bit words
`define WB_MEM_WORDS 256

// First byte address that answers with err
// Equal to the SRAM size in bytes, so nothing aliases into the memory
`define WB_ADDR_LIMIT 32'h0000_0400

`endif

/* wb_pkg.sv */
// Wishbone B3 encodings

package wb_pkg;

    //////////////////////////////////////////////////////////////////////
    // Cycle type identifier (CTI)
    //////////////////////////////////////////////////////////////////////

    // Carried with every strobe
    // Classic for single cycles, incrementing for burst beats
    typedef enum logic [2:0] {
        // Plain single access
        CTI_CLASSIC = 3'b000,
        // Constant address burst, never issued by the bridge
        CTI_CONST   = 3'b001,
        // Incrementing burst, address moves per bte
        CTI_INCR    = 3'b010,
        // Final beat of any burst
        CTI_EOB     = 3'b111
    } cti_t;

    //////////////////////////////////////////////////////////////////////
    // Burst type extension (BTE)
    //////////////////////////////////////////////////////////////////////

    // Wrap size of an incrementing burst
    typedef enum logic [1:0] {
        // Unbounded, not used by this bridge
        BTE_LINEAR = 2'b00,
        // 4 beat wrap
        BTE_WRAP4  = 2'b01,
        // 8 beat wrap
        BTE_WRAP8  = 2'b10,
        // 16 beat wrap
        BTE_WRAP16 = 2'b11
    } bte_t;

endpackage

/* cpu_bus_pkg.sv */
// CPU side address and control types

`include "wb32_consts.svh"

package cpu_bus_pkg;

    // Flat view of a byte address
    // Word index plus offset inside the word
    typedef struct packed {
        logic [29:0] word;
        logic [1:0]  byte_off;
    } cpu_addr_flat_t;

    // Line view of the same address
    // Line base, beat within the wrap line, byte offset
    typedef struct packed {
        logic [31-`WB_BEAT_BITS-2:0] base;
        logic [`WB_BEAT_BITS-1:0]    beat;
        logic [1:0]                  byte_off;
    } cpu_addr_line_t;

    // One 32-bit address, two decodings
    // SRAM slave indexes with flat, beat counter works on line
    typedef union packed {
        cpu_addr_flat_t flat;
        cpu_addr_line_t line;
    } cpu_addr_u;

    // Burst state machine states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        SINGLE = 2'b01,
        BURST  = 2'b10,
        DRAIN  = 2'b11
    } burst_state_t;

endpackage

/* wb_burst_fsm.sv */
// Wishbone burst state machine

`timescale 1ns/1ps

module wb_burst_fsm (
    input  logic clk,
    input  logic rst,
    input  logic cpu_req_i,
    input  logic cpu_we_i,
    input  logic wb_ack_i,
    input  logic wb_err_i,
    input  logic on_sequence_i,
    input  logic at_wrap_end_i,
    output logic start_single_o,
    output logic start_burst_o,
    output logic in_burst_o,
    output logic last_beat_o,
    output logic hold_off_o,
    output logic load_o,
    output logic advance_o
);

    cpu_bus_pkg::burst_state_t state_q;
    cpu_bus_pkg::burst_state_t state_d;

    //////////////////////////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= cpu_bus_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            // Reads open a wrapping burst, writes go out as classic cycles
            cpu_bus_pkg::IDLE: begin
                if (cpu_req_i) begin
                    state_d = cpu_we_i ? cpu_bus_pkg::SINGLE : cpu_bus_pkg::BURST;
                end
            end
            cpu_bus_pkg::SINGLE: begin
                if (wb_ack_i) begin
                    state_d = cpu_bus_pkg::IDLE;
                end
            end
            // Close after the beat flagged as last completes
            cpu_bus_pkg::BURST: begin
                if (wb_ack_i && last_beat_o) begin
                    state_d = cpu_bus_pkg::IDLE;
                end
            end
            default: state_d = cpu_bus_pkg::IDLE;
        endcase
        // Error from anywhere, one idle cycle in DRAIN
        if (wb_err_i && state_q != cpu_bus_pkg::DRAIN) begin
            state_d = cpu_bus_pkg::DRAIN;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Control outputs
    //////////////////////////////////////////////////////////////////////

    // Classic access on the bus, first cycle straight from IDLE
    assign start_single_o = cpu_req_i &&
                            ((state_q == cpu_bus_pkg::IDLE && cpu_we_i) ||
                             state_q == cpu_bus_pkg::SINGLE);
    assign start_burst_o  = cpu_req_i && !cpu_we_i && state_q == cpu_bus_pkg::IDLE;
    assign in_burst_o     = (state_q == cpu_bus_pkg::BURST);

    // Wrap point, address break or dropped request
    assign last_beat_o = in_burst_o && (at_wrap_end_i || !on_sequence_i || !cpu_req_i);

    // Closing beat completes, strobe must drop next cycle
    assign hold_off_o = wb_err_i ||
                        (wb_ack_i && (state_q == cpu_bus_pkg::SINGLE || last_beat_o));

    // Beat counter control
    assign load_o    = start_burst_o;
    assign advance_o = in_burst_o && wb_ack_i;

    // Burst only ever opens on a read
    assert property (@(posedge clk) disable iff (rst) $rose(in_burst_o) |-> !cpu_we_i);

    // DRAIN gives exactly one idle cycle
    assert property (@(posedge clk) disable iff (rst)
        state_q == cpu_bus_pkg::DRAIN |=> state_q == cpu_bus_pkg::IDLE);

endmodule

/* wb_beat_counter.sv */
// Wrapping burst beat counter

`timescale 1ns/1ps

`include "wb32_consts.svh"

module wb_beat_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_i,
    input  logic                  advance_i,
    input  cpu_bus_pkg::cpu_addr_u cpu_adr_i,
    output cpu_bus_pkg::cpu_addr_u burst_adr_o,
    output logic                  on_sequence_o,
    output logic                  at_wrap_end_o
);

    // Beat the burst began on, wrap ends one before it
    logic [`WB_BEAT_BITS-1:0] start_beat_q;
    logic [`WB_BEAT_BITS-1:0] wrap_last;
    logic [`WB_BEAT_BITS-1:0] beat_inc;

    // Next beat inside the line, modulo burst length
    assign beat_inc  = `WB_BEAT_BITS'((32'(burst_adr_o.line.beat) + 32'd1) % `WB_BURST_LEN);
    assign wrap_last = start_beat_q - 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Base address and beat registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            burst_adr_o  <= '0;
            start_beat_q <= '0;
        end else if (load_i) begin
            // Capture line and starting beat, bytes always word aligned
            burst_adr_o.line.base     <= cpu_adr_i.line.base;
            burst_adr_o.line.beat     <= cpu_adr_i.line.beat;
            burst_adr_o.line.byte_off <= 2'b00;
            start_beat_q              <= cpu_adr_i.line.beat;
        end else if (advance_i) begin
            // Line base stays fixed
            burst_adr_o.line.beat <= beat_inc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Status back to the state machine
    //////////////////////////////////////////////////////////////////////

    // CPU follows the beat sequence, byte offset ignored
    assign on_sequence_o = (cpu_adr_i.flat.word == burst_adr_o.flat.word);

    assign at_wrap_end_o = (burst_adr_o.line.beat == wrap_last);

endmodule

/* wb_master_port.sv */
// Wishbone master port

`timescale 1ns/1ps

`include "wb32_consts.svh"

module wb_master_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           cpu_adr_i,
    input  logic [31:0]           cpu_dat_i,
    input  logic [3:0]            cpu_bsel_i,
    input  logic                  cpu_we_i,
    input  logic                  cpu_req_i,
    input  logic                  start_single_i,
    input  logic                  start_burst_i,
    input  logic                  in_burst_i,
    input  logic                  last_beat_i,
    input  logic                  hold_off_i,
    input  logic                  on_sequence_i,
    input  cpu_bus_pkg::cpu_addr_u burst_adr_i,
    input  logic                  wb_ack_i,
    input  logic                  wb_err_i,
    input  logic [31:0]           wb_dat_i,
    output logic [31:0]           wb_adr_o,
    output logic [31:0]           wb_dat_o,
    output logic [3:0]            wb_sel_o,
    output logic                  wb_we_o,
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output wb_pkg::cti_t          wb_cti_o,
    output wb_pkg::bte_t          wb_bte_o,
    output logic                  cpu_ack_o,
    output logic                  cpu_err_o,
    output logic [31:0]           cpu_dat_o
);

    // Set for the cycle right after a closing ack or err
    logic cycle_end_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_end_q <= 1'b0;
        end else begin
            cycle_end_q <= hold_off_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////////////////////////

    // Bus claimed already in the burst load cycle
    assign wb_cyc_o = in_burst_i || start_single_i || start_burst_i;
    assign wb_stb_o = (in_burst_i || start_single_i) && !cycle_end_q;

    assign wb_adr_o = in_burst_i ? burst_adr_i : cpu_adr_i;
    assign wb_dat_o = cpu_dat_i;
    assign wb_sel_o = cpu_bsel_i;
    assign wb_we_o  = cpu_we_i;

    // End of burst on the closing beat, classic otherwise
    assign wb_cti_o = !in_burst_i ? wb_pkg::CTI_CLASSIC :
                      last_beat_i ? wb_pkg::CTI_EOB : wb_pkg::CTI_INCR;

    assign wb_bte_o = (`WB_BURST_LEN == 4)  ? wb_pkg::BTE_WRAP4 :
                      (`WB_BURST_LEN == 8)  ? wb_pkg::BTE_WRAP8 :
                      (`WB_BURST_LEN == 16) ? wb_pkg::BTE_WRAP16 : wb_pkg::BTE_LINEAR;

    //////////////////////////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////////////////////////

    // Beat at the expected address is not what the CPU asked for
    assign cpu_ack_o = wb_ack_i && cpu_req_i && !(in_burst_i && !on_sequence_i);
    assign cpu_err_o = wb_err_i;
    assign cpu_dat_o = wb_err_i ? 32'h0 : wb_dat_i;

    assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o);

endmodule

/* wb_sram_slave.sv */
// Wishbone SRAM slave

`timescale 1ns/1ps

`include "wb32_consts.svh"

module wb_sram_slave (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_bus_pkg::cpu_addr_u wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    input  logic [3:0]            wb_sel_i,
    input  logic                  wb_we_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  wb_pkg::cti_t          wb_cti_i,
    input  wb_pkg::bte_t          wb_bte_i,
    output logic                  wb_ack_o,
    output logic                  wb_err_o,
    output logic [31:0]           wb_dat_o
);

    localparam int IDX_W = $clog2(`WB_MEM_WORDS);

    logic [31:0]      mem [`WB_MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             in_range;
    logic             burst_cont;
    logic             accept;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // Word index from the flat view
    assign idx      = wb_adr_i.flat.word[IDX_W-1:0];
    assign in_range = (wb_adr_i < `WB_ADDR_LIMIT);

    // Wrapping burst keeps acking back to back until end of burst
    // Linear bursts are served as classic cycles
    assign burst_cont = wb_ack_o && wb_cti_i == wb_pkg::CTI_INCR &&
                        wb_bte_i != wb_pkg::BTE_LINEAR;

    // New cycle, or next beat of a running burst
    assign accept = wb_cyc_i && wb_stb_i && (!(wb_ack_o || wb_err_o) || burst_cont);

    //////////////////////////////////////////////////////////////////////
    // Registered response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
        end else begin
            wb_ack_o <= accept && in_range;
            wb_err_o <= accept && !in_range;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // Byte lane writes, out of range leaves memory alone
    always_ff @(posedge clk) begin
        if (accept && wb_we_i && in_range) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wb_sel_i[lane]) begin
                    mem[idx][8*lane +: 8] <= wb_dat_i[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read, data follows the address of the acked beat
    assign wb_dat_o = mem[idx];

    assert property (@(posedge clk) disable iff (rst) !(wb_ack_o && wb_err_o));

endmodule

/* wb32_bus_if.sv */
// CPU to Wishbone bridge top

`timescale 1ns/1ps

module wb32_bus_if (
    input  logic         clk,
    input  logic         rst,
    input  logic         cpu_req_i,
    input  logic         cpu_we_i,
    input  logic [31:0]  cpu_adr_i,
    input  logic [31:0]  cpu_dat_i,
    input  logic [3:0]   cpu_bsel_i,
    output logic         cpu_ack_o,
    output logic         cpu_err_o,
    output logic [31:0]  cpu_dat_o,
    output logic         wbm_cyc_o,
    output logic         wbm_stb_o,
    output wb_pkg::cti_t wbm_cti_o
);

    // State machine control
    logic start_single;
    logic start_burst;
    logic in_burst;
    logic last_beat;
    logic hold_off;
    logic load;
    logic advance;

    // Beat counter status
    cpu_bus_pkg::cpu_addr_u burst_adr;
    logic                   on_sequence;
    logic                   at_wrap_end;

    // Internal Wishbone bus, cyc, stb and cti run on the monitor ports
    logic [31:0]  wb_adr;
    logic [31:0]  wb_dat_w;
    logic [3:0]   wb_sel;
    logic         wb_we;
    wb_pkg::bte_t wb_bte;
    logic         wb_ack;
    logic         wb_err;
    logic [31:0]  wb_dat_r;

    //////////////////////////////////////////////////////////////////////
    // Bridge
    //////////////////////////////////////////////////////////////////////

    wb_burst_fsm u_fsm (
        .clk(clk), .rst(rst),
        .cpu_req_i(cpu_req_i), .cpu_we_i(cpu_we_i),
        .wb_ack_i(wb_ack), .wb_err_i(wb_err),
        .on_sequence_i(on_sequence), .at_wrap_end_i(at_wrap_end),
        .start_single_o(start_single), .start_burst_o(start_burst),
        .in_burst_o(in_burst), .last_beat_o(last_beat), .hold_off_o(hold_off),
        .load_o(load), .advance_o(advance)
    );

    wb_beat_counter u_beat (
        .clk(clk), .rst(rst),
        .load_i(load), .advance_i(advance), .cpu_adr_i(cpu_adr_i),
        .burst_adr_o(burst_adr), .on_sequence_o(on_sequence),
        .at_wrap_end_o(at_wrap_end)
    );

    wb_master_port u_master (
        .clk(clk), .rst(rst),
        .cpu_adr_i(cpu_adr_i), .cpu_dat_i(cpu_dat_i), .cpu_bsel_i(cpu_bsel_i),
        .cpu_we_i(cpu_we_i), .cpu_req_i(cpu_req_i),
        .start_single_i(start_single), .start_burst_i(start_burst),
        .in_burst_i(in_burst), .last_beat_i(last_beat), .hold_off_i(hold_off),
        .on_sequence_i(on_sequence), .burst_adr_i(burst_adr),
        .wb_ack_i(wb_ack), .wb_err_i(wb_err), .wb_dat_i(wb_dat_r),
        .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_we_o(wb_we),
        .wb_cyc_o(wbm_cyc_o), .wb_stb_o(wbm_stb_o), .wb_cti_o(wbm_cti_o),
        .wb_bte_o(wb_bte),
        .cpu_ack_o(cpu_ack_o), .cpu_err_o(cpu_err_o), .cpu_dat_o(cpu_dat_o)
    );

    //////////////////////////////////////////////////////////////////////
    // SRAM slave
    //////////////////////////////////////////////////////////////////////

    wb_sram_slave u_sram (
        .clk(clk), .rst(rst),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_we_i(wb_we),
        .wb_cyc_i(wbm_cyc_o), .wb_stb_i(wbm_stb_o), .wb_cti_i(wbm_cti_o),
        .wb_bte_i(wb_bte),
        .wb_ack_o(wb_ack), .wb_err_o(wb_err), .wb_dat_o(wb_dat_r)
    );

endmodule

/* tb_wb32_bus_if.sv */
// Wishbone bridge testbench

`timescale 1ns/1ps

`include "wb32_consts.svh"

module tb_wb32_bus_if;

    localparam int CLK_PERIOD = 100;
    localparam int N_RAND     = 24;
    localparam int N_BURSTS   = 6;
    localparam int N_BREAKS   = 2;
    localparam int RESP_LIMIT = 16;
    localparam int N_LINES    = `WB_MEM_WORDS / `WB_BURST_LEN;
    // Rough cycles per test summed over the run
    localparam int TEST_CYCLES = 4 + `WB_MEM_WORDS * 4 + N_RAND * 10 +
                                 N_BURSTS * (`WB_BURST_LEN + 8) + N_BREAKS * 16 + 30;

    logic         clk;
    logic         rst;
    logic         cpu_req;
    logic         cpu_we;
    logic [31:0]  cpu_adr;
    logic [31:0]  cpu_dat;
    logic [3:0]   cpu_bsel;
    logic         cpu_ack;
    logic         cpu_err;
    logic [31:0]  cpu_rdata;
    logic         wbm_cyc;
    logic         wbm_stb;
    wb_pkg::cti_t wbm_cti;

    // Reference copy of the SRAM
    logic [31:0] ref_mem [`WB_MEM_WORDS];
    logic [31:0] rand_adr [N_RAND];

    int    errors        = 0;
    int    tests_run     = 0;
    int    tests_failed  = 0;
    int    test_err_base = 0;
    string test_name     = "init";

    wb32_bus_if DUT (
        .clk(clk), .rst(rst),
        .cpu_req_i(cpu_req), .cpu_we_i(cpu_we), .cpu_adr_i(cpu_adr),
        .cpu_dat_i(cpu_dat), .cpu_bsel_i(cpu_bsel),
        .cpu_ack_o(cpu_ack), .cpu_err_o(cpu_err), .cpu_dat_o(cpu_rdata),
        .wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_cti_o(wbm_cti)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Bus protocol assertions
    //////////////////////////////////////////////////////////////////////

    // Nothing active in the cycle after a reset edge
    assert property (@(posedge clk) rst |=> !cpu_ack && !cpu_err && !wbm_cyc && !wbm_stb)
        else begin
            errors++;
            $display("%s: CPU response or bus active right after reset", test_name);
        end

    // Writes are always classic cycles
    assert property (@(posedge clk) disable iff (rst)
        wbm_stb && cpu_we |-> wbm_cti == wb_pkg::CTI_CLASSIC)
        else begin
            errors++;
            $display("** Error %s: write cti expected %b actual %b", test_name,
                     wb_pkg::CTI_CLASSIC, $sampled(wbm_cti));
        end

    // Reads always run as wrapping bursts
    assert property (@(posedge clk) disable iff (rst)
        wbm_stb && !cpu_we |-> wbm_cti inside {wb_pkg::CTI_INCR, wb_pkg::CTI_EOB})
        else begin
            errors++;
            $display("** Error %s: read cti expected 010 or 111 actual %b", test_name,
                     $sampled(wbm_cti));
        end

    assert property (@(posedge clk) disable iff (rst) cpu_err |-> cpu_rdata == 32'h0)
        else begin
            errors++;
            $display("** Error %s: data on error expected 00000000 actual %h", test_name,
                     $sampled(cpu_rdata));
        end

    // Strobe gap after the closing beat
    assert property (@(posedge clk) disable iff (rst)
        wbm_stb && wbm_cti == wb_pkg::CTI_EOB |=> !wbm_stb)
        else begin
            errors++;
            $display("%s: strobe still high after an end of burst beat", test_name);
        end

    assert property (@(posedge clk) disable iff (rst) !(cpu_ack && cpu_err))
        else begin
            errors++;
            $display("%s: acknowledge and error high together", test_name);
        end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Word pattern built from the full word index
    function automatic logic [31:0] fill_value(input logic [7:0] w);
        return {~w, w ^ 8'h5A, w, w + 8'h33};
    endfunction

    // Byte lane merge of a write into the old word
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  bsel);
        logic [31:0] mask;
        mask = {{8{bsel[3]}}, {8{bsel[2]}}, {8{bsel[1]}}, {8{bsel[0]}}};
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    function automatic logic [31:0] beat_adr(input int line, input int beat);
        return 32'((line * `WB_BURST_LEN + (beat % `WB_BURST_LEN)) * 4);
    endfunction

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("[%0t] test %s: passed", $time, test_name);
        end else begin
            tests_failed++;
            $display("[%0t] test %s: failed with %0d errors", $time, test_name,
                     errors - test_err_base);
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic require(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s: %s", test_name, msg);
        end
    endtask

    // Sample at falling edges until ack or err shows up
    task automatic wait_response(output logic ack, output logic err, output int waited);
        ack    = 1'b0;
        err    = 1'b0;
        waited = 0;
        while (!ack && !err && waited < RESP_LIMIT) begin
            @(negedge clk);
            waited++;
            ack = cpu_ack;
            err = cpu_err;
        end
        require(ack || err, $sformatf("no acknowledge or error within %0d cycles",
                                      RESP_LIMIT));
    endtask

    //////////////////////////////////////////////////////////////////////
    // CPU side accesses
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input logic [31:0] adr, input logic [31:0] data,
                              input logic [3:0] bsel, input logic expect_err);
        logic ack;
        logic err;
        int   waited;
        int   word;
        word = int'(adr[31:2]) % `WB_MEM_WORDS;
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_we   <= 1'b1;
        cpu_adr  <= adr;
        cpu_dat  <= data;
        cpu_bsel <= bsel;
        wait_response(ack, err, waited);
        compare_word("write error flag", 32'(expect_err), 32'(err));
        if (ack && !expect_err) begin
            ref_mem[word] = merge_lanes(ref_mem[word], data, bsel);
        end
        @(posedge clk);
        cpu_req <= 1'b0;
        cpu_we  <= 1'b0;
    endtask

    // Isolated read that drops the request after the first beat
    task automatic read_word(input logic [31:0] adr, input logic expect_err);
        logic        ack;
        logic        err;
        int          waited;
        logic [31:0] exp_data;
        exp_data = expect_err ? 32'h0 : ref_mem[int'(adr[31:2]) % `WB_MEM_WORDS];
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_we   <= 1'b0;
        cpu_adr  <= adr;
        cpu_bsel <= 4'hF;
        wait_response(ack, err, waited);
        compare_word("read error flag", 32'(expect_err), 32'(err));
        if (ack || err) begin
            compare_word("read data", exp_data, cpu_rdata);
        end
        @(posedge clk);
        cpu_req <= 1'b0;
    endtask

    // CPU follows the wrap order for a whole line
    task automatic burst_read(input int line, input int start);
        logic         ack;
        logic         err;
        int           waited;
        int           beat;
        wb_pkg::cti_t exp_cti;
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_we   <= 1'b0;
        cpu_bsel <= 4'hF;
        cpu_adr  <= beat_adr(line, start);
        for (int k = 0; k < `WB_BURST_LEN; k++) begin
            beat    = (start + k) % `WB_BURST_LEN;
            exp_cti = (k == `WB_BURST_LEN - 1) ? wb_pkg::CTI_EOB : wb_pkg::CTI_INCR;
            wait_response(ack, err, waited);
            if (!ack) begin
                require(1'b0, $sformatf("burst beat %0d not acknowledged", k));
                @(posedge clk);
                break;
            end
            compare_word($sformatf("beat %0d data", k),
                         ref_mem[line * `WB_BURST_LEN + beat], cpu_rdata);
            compare_word($sformatf("beat %0d cti", k), 32'(exp_cti), 32'(wbm_cti));
            if (k > 0) begin
                require(waited == 1, $sformatf("beat %0d not back to back", k));
            end
            @(posedge clk);
            if (k < `WB_BURST_LEN - 1) begin
                cpu_adr <= beat_adr(line, beat + 1);
            end
        end
        cpu_req <= 1'b0;
        // Exactly one line of acks
        repeat (4) begin
            @(negedge clk);
            require(!cpu_ack && !wbm_stb, "strobe or acknowledge after the final burst beat");
        end
    endtask

    // Jump to another line after the first beat
    task automatic break_burst(input int line, input int start,
                               input int new_line, input int new_beat);
        logic ack;
        logic err;
        int   waited;
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_we   <= 1'b0;
        cpu_bsel <= 4'hF;
        cpu_adr  <= beat_adr(line, start);
        wait_response(ack, err, waited);
        compare_word("first beat data", ref_mem[line * `WB_BURST_LEN + start], cpu_rdata);
        @(posedge clk);
        cpu_adr <= beat_adr(new_line, new_beat);
        @(negedge clk);
        require(!cpu_ack, "acknowledge on the off-sequence beat");
        compare_word("break beat cti", 32'(wb_pkg::CTI_EOB), 32'(wbm_cti));
        wait_response(ack, err, waited);
        require(ack, "access after the break not acknowledged");
        compare_word("new access data", ref_mem[new_line * `WB_BURST_LEN + new_beat],
                     cpu_rdata);
        @(posedge clk);
        cpu_req <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          line;
        int          word;
        logic [31:0] adr;
        void'($urandom(16));
        rst      = 1'b1;
        cpu_req  = 1'b0;
        cpu_we   = 1'b0;
        cpu_adr  = 32'h0;
        cpu_dat  = 32'h0;
        cpu_bsel = 4'h0;

        begin_test("reset");
        @(posedge clk);
        @(negedge clk);
        require(!cpu_ack && !cpu_err && !wbm_cyc && !wbm_stb, "bus active during reset");
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        require(!cpu_ack && !cpu_err && !wbm_cyc && !wbm_stb, "bus active after reset");
        end_test();

        begin_test("fill");
        for (int w = 0; w < `WB_MEM_WORDS; w++) begin
            write_word(32'(w * 4), fill_value(8'(w)), 4'hF, 1'b0);
        end
        end_test();

        // Random lanes with repeated words allowed
        begin_test("single_write_read");
        for (int i = 0; i < N_RAND; i++) begin
            rand_adr[i] = 32'(($urandom % `WB_MEM_WORDS) * 4);
            write_word(rand_adr[i], $urandom, 4'($urandom), 1'b0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            read_word(rand_adr[i], 1'b0);
        end
        end_test();

        begin_test("wrap_burst");
        for (int i = 0; i < N_BURSTS; i++) begin
            burst_read($urandom % N_LINES, $urandom % `WB_BURST_LEN);
        end
        end_test();

        begin_test("address_break");
        for (int i = 0; i < N_BREAKS; i++) begin
            line = $urandom % N_LINES;
            break_burst(line, $urandom % `WB_BURST_LEN, (line + 1) % N_LINES,
                        $urandom % `WB_BURST_LEN);
        end
        end_test();

        // Out of range word aliases onto an in-range index
        begin_test("out_of_range");
        word = $urandom % `WB_MEM_WORDS;
        adr  = `WB_ADDR_LIMIT + 32'(word * 4);
        read_word(adr, 1'b1);
        write_word(adr, ~ref_mem[word], 4'hF, 1'b1);
        read_word(32'(word * 4), 1'b0);
        read_word(32'(((word + 1) % `WB_MEM_WORDS) * 4), 1'b0);
        end_test();

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run,
                 tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles, the DUT seems hung",
                 TEST_CYCLES * 4);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* wb32_bus_if.f */
+incdir+.
wb_pkg.sv
cpu_bus_pkg.sv
wb_burst_fsm.sv
wb_beat_counter.sv
wb_master_port.sv
wb_sram_slave.sv
wb32_bus_if.sv
tb_wb32_bus_if.sv

/* Bender.yml */
package:
  name: wb32_bus_if

export_include_dirs:
  - .

sources:
  # RTL in compile order
  - include_dirs:
      - .
    files:
      - wb_pkg.sv
      - cpu_bus_pkg.sv
      - wb_burst_fsm.sv
      - wb_beat_counter.sv
      - wb_master_port.sv
      - wb_sram_slave.sv
      - wb32_bus_if.sv

  # Testbench
  - target: test
    include_dirs:
      - .
    files:
      - tb_wb32_bus_if.sv
